//--- hw/cart_ddr_port.sv
// cartridge DDR port
// turns core cart bus activity into single DDR reads, drives the core wait
// line, and lets loader writes use the same port while a load runs
`timescale 1ns/1ps
`default_nettype none

module cart_ddr_port import mem_map_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	// loader side
	input  wire                    loader_active,
	input  wire                    wr_pending,
	input  wire [ABUS_W-1:0]       wr_addr,
	input  wire [DDR_DATA_W-1:0]   wr_data,
	input  wire [DDR_BE_W-1:0]     wr_be,
	output logic                   wr_accept,
	// core cart bus
	input  wire                    cart_ce_n,
	input  wire [ABUS_W-1:0]       abus,
	output logic [CART_DATA_W-1:0] cart_q,
	output logic                   xwaitl,
	// DDR
	input  wire                    ddram_busy,
	input  wire [DDR_DATA_W-1:0]   ddram_dout,
	input  wire                    ddram_dout_ready,
	output logic                   ddram_rd,
	output logic                   ddram_we,
	output logic [DDR_ADDR_W-1:0]  ddram_addr,
	output logic [DDR_DATA_W-1:0]  ddram_din,
	output logic [DDR_BE_W-1:0]    ddram_be
);

	logic              cart_ce_n_d;
	logic [ABUS_W-1:0] abus_d;
	logic              rd_trig;
	logic              rd_load;
	logic [ABUS_W-4:0] rd_row;   // abus[23:3] of the held read

	// new cart access, ce falling or address moved
	assign rd_trig = ~cart_ce_n & ~loader_active & (cart_ce_n_d | (abus != abus_d));

	// take a new read when the port is free or the held one goes this edge
	assign rd_load = rd_trig & (~ddram_rd | ~ddram_busy);

	// ====================
	// read request and wait line
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cart_ce_n_d <= 1'b1;
			abus_d      <= '0;
			ddram_rd    <= 1'b0;
			xwaitl      <= 1'b1;
		end else begin
			cart_ce_n_d <= cart_ce_n;
			abus_d      <= abus;

			if (rd_load)
				ddram_rd <= 1'b1;
			else if (ddram_rd && !ddram_busy)
				ddram_rd <= 1'b0;   // accepted

			if (rd_trig)
				xwaitl <= 1'b0;   // core waits for the data
			else if (ddram_dout_ready)
				xwaitl <= 1'b1;
		end
	end

	// address held with the request
	always_ff @(posedge clk_sys) begin
		if (rd_load)
			rd_row <= abus[ABUS_W-1:3];
	end

	// ====================
	// write path, a held read goes first
	assign ddram_we  = loader_active & wr_pending & ~ddram_rd;
	assign wr_accept = ddram_we & ~ddram_busy;

	assign ddram_addr = loader_active ? {DDR_REGION, wr_addr[ABUS_W-1:3]}
	                                  : {DDR_REGION, rd_row};
	assign ddram_din  = wr_data;
	assign ddram_be   = loader_active ? wr_be : '1;   // reads take the whole beat

	// 32-bit cart, abus[2] picks the half
	assign cart_q = abus[2] ? ddram_dout[CART_DATA_W-1:0]
	                        : ddram_dout[DDR_DATA_W-1:CART_DATA_W];

	// ====================
	// checks
	a_rd_we_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ddram_rd && ddram_we));

	a_rd_held: assert property (@(posedge clk_sys) disable iff (reset)
		ddram_rd && ddram_busy |=> ddram_rd && $stable(ddram_addr));

endmodule

`default_nettype wire

//--- hw/cart_loader.sv
// cartridge loader
// writes host download words into the DDR cart area, one DDR write per word,
// and holds the host off with ioctl_wait until each write is taken
`timescale 1ns/1ps
`default_nettype none

module cart_loader import mem_map_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    ioctl_download,
	input  wire                    ioctl_wr,
	input  wire [IOCTL_IDX_W-1:0]  ioctl_index,
	input  wire [LOAD_WORD_W-1:0]  ioctl_data,
	input  wire                    wr_accept,
	output logic                   ioctl_wait,
	output logic                   core_run,
	output logic                   loader_active,
	output logic                   wr_pending,
	output logic [ABUS_W-1:0]      wr_addr,
	output logic [DDR_DATA_W-1:0]  wr_data,
	output logic [DDR_BE_W-1:0]    wr_be
);

	logic old_download;
	logic dl_rise, dl_fall;
	logic [LOAD_WORD_W-1:0] word_swapped;

	assign dl_rise = ~old_download & ioctl_download;
	assign dl_fall = old_download & ~ioctl_download;

	// host sends little endian, core wants big endian
	assign word_swapped = {ioctl_data[7:0], ioctl_data[15:8]};

	// core stays in reset for any download, boot rom too
	assign core_run = ~ioctl_download;

	// ====================
	// download tracking
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_download  <= 1'b0;
			loader_active <= 1'b0;
			wr_pending    <= 1'b0;
			ioctl_wait    <= 1'b0;
			wr_addr       <= CART_LOAD_BASE;
		end else begin
			old_download <= ioctl_download;

			if (dl_rise && ioctl_index != '0) begin   // index 0 is not a cart
				loader_active <= 1'b1;
				wr_addr       <= CART_LOAD_BASE;
			end else if (dl_fall)
				loader_active <= 1'b0;

			if (ioctl_wr && loader_active) begin
				wr_pending <= 1'b1;
				ioctl_wait <= 1'b1;   // hold host until DDR takes it
			end else if (wr_accept) begin
				wr_pending <= 1'b0;
				ioctl_wait <= 1'b0;
				wr_addr    <= wr_addr + 2'd2;   // next 16-bit word
			end
		end
	end

	// word goes to every lane, byte enables pick the real one
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && loader_active)
			wr_data <= {LOAD_REPEAT{word_swapped}};
	end

	// byte pair from addr[2:1], 0 is the top pair
	always_comb begin
		case (wr_addr[2:1])
			2'd0:    wr_be = 8'b1100_0000;
			2'd1:    wr_be = 8'b0011_0000;
			2'd2:    wr_be = 8'b0000_1100;
			default: wr_be = 8'b0000_0011;
		endcase
	end

	// ====================
	// checks
	a_addr_even: assert property (@(posedge clk_sys) disable iff (reset)
		wr_addr[0] == 1'b0);

	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> !ioctl_wait);

endmodule

`default_nettype wire

//--- hw/dram_bridge.sv
// core DRAM to SDRAM channel bridge
// one core access at a time, each becomes a single 64-bit channel request
`timescale 1ns/1ps
`default_nettype none

module dram_bridge import mem_map_pkg::*; import dram_bus_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	// core DRAM bus
	input  wire [ABUS_W-1:0]       abus,
	input  wire                    startcas,
	input  wire                    dram_cas_n,
	input  wire [DRAM_LANES-1:0]   dram_oe_n,
	input  wire [DRAM_LANES-1:0]   dram_uw_n,
	input  wire [DRAM_LANES-1:0]   dram_lw_n,
	input  wire [DRAM_DATA_W-1:0]  dram_d,
	output logic [DRAM_DATA_W-1:0] dram_q,
	output logic [DRAM_LANES-1:0]  dram_oe,
	output logic                   ram_rdy,
	// SDRAM channel 1
	input  wire                    ch1_ready,
	input  wire [DRAM_DATA_W-1:0]  ch1_dout,
	output logic [CH1_ADDR_W-1:0]  ch1_addr,
	output logic                   ch1_req,
	output logic                   ch1_rnw,
	output logic [DRAM_BE_W-1:0]   ch1_be,
	output logic [DRAM_DATA_W-1:0] ch1_din
);

	mem_cyc_e              state;
	logic                  rd_strobe;
	logic                  wr_strobe;
	logic [DRAM_BE_W-1:0]  be_lanes;

	assign rd_strobe = startcas & (dram_oe_n != '1);
	assign wr_strobe = ~dram_cas_n & ({dram_uw_n, dram_lw_n} != '1);

	// strobes are active low, upper byte above lower in each lane
	always_comb begin
		for (int i = 0; i < DRAM_LANES; i++) begin
			be_lanes[2*i+1] = ~dram_uw_n[i];
			be_lanes[2*i]   = ~dram_lw_n[i];
		end
	end

	// ====================
	// cycle FSM
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state   <= RAM_IDLE;
			ch1_req <= 1'b0;
		end else begin
			ch1_req <= 1'b0;   // single cycle pulse
			case (state)
				RAM_IDLE: if (rd_strobe || wr_strobe) begin
					ch1_req <= 1'b1;
					state   <= RDY_WAIT;
				end
				RDY_WAIT: if (ch1_ready)
					state <= RAM_END;
				RAM_END: if (dram_cas_n)   // core has to let go of cas first
					state <= RAM_IDLE;
				default: state <= RAM_IDLE;
			endcase
		end
	end

	// request payload, captured with the strobe
	always_ff @(posedge clk_sys) begin
		if (state == RAM_IDLE && (rd_strobe || wr_strobe)) begin
			ch1_rnw <= ~wr_strobe;   // write wins if both show up
			ch1_be  <= be_lanes;
			ch1_din <= dram_d;
		end
	end

	// 64-bit aligned, burst of four 16-bit words
	assign ch1_addr = {{(CH1_ADDR_W-22){1'b0}}, abus[22:3], 2'b00};

	// data is valid in the ready cycle already
	assign ram_rdy = (state == RDY_WAIT && ch1_ready) || (state == RAM_END);
	assign dram_q  = ch1_dout;
	assign dram_oe = dram_cas_n ? '0 : ~dram_oe_n;

	// ====================
	// checks
	a_req_from_idle: assert property (@(posedge clk_sys) disable iff (reset)
		ch1_req |-> state == RDY_WAIT && $past(state) == RAM_IDLE);

	a_wait_for_ready: assert property (@(posedge clk_sys) disable iff (reset)
		state == RDY_WAIT && !ch1_ready |=> state == RDY_WAIT);

endmodule

`default_nettype wire

//--- hw/dram_bus_pkg.sv
// DRAM side definitions
// core strobe lanes, SDRAM channel widths and the bridge states
`default_nettype none

package dram_bus_pkg;

	// ====================
	// core DRAM bus
	localparam int DRAM_LANES  = 4;                // one oe/uw/lw strobe per 16-bit lane
	localparam int DRAM_DATA_W = 64;
	localparam int DRAM_BE_W   = 2 * DRAM_LANES;   // upper + lower byte per lane

	// ====================
	// SDRAM channel
	localparam int CH1_ADDR_W  = 26;   // 16-bit word address, burst of 4

	// bridge cycle states
	typedef enum logic [1:0] {
		RAM_IDLE = 2'b00,   // waiting for a core strobe
		RDY_WAIT = 2'b01,   // request issued, waiting on ch1_ready
		RAM_END  = 2'b11    // data ready, waiting for cas to drop
	} mem_cyc_e;

endpackage

`default_nettype wire

//--- hw/jag_mem_glue.sv
// memory glue top
// cart loader and DDR port share the DDR, DRAM bridge feeds the SDRAM channel
`timescale 1ns/1ps
`default_nettype none

module jag_mem_glue import mem_map_pkg::*; import dram_bus_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	// host download
	input  wire                    ioctl_download,
	input  wire                    ioctl_wr,
	input  wire [IOCTL_IDX_W-1:0]  ioctl_index,
	input  wire [LOAD_WORD_W-1:0]  ioctl_data,
	output logic                   ioctl_wait,
	output logic                   core_run,
	// core cart bus
	input  wire                    cart_ce_n,
	input  wire [ABUS_W-1:0]       abus,
	output logic [CART_DATA_W-1:0] cart_q,
	output logic                   xwaitl,
	// DDR
	input  wire                    ddram_busy,
	input  wire [DDR_DATA_W-1:0]   ddram_dout,
	input  wire                    ddram_dout_ready,
	output logic                   ddram_rd,
	output logic                   ddram_we,
	output logic [DDR_ADDR_W-1:0]  ddram_addr,
	output logic [DDR_DATA_W-1:0]  ddram_din,
	output logic [DDR_BE_W-1:0]    ddram_be,
	// core DRAM bus
	input  wire                    startcas,
	input  wire                    dram_cas_n,
	input  wire [DRAM_LANES-1:0]   dram_oe_n,
	input  wire [DRAM_LANES-1:0]   dram_uw_n,
	input  wire [DRAM_LANES-1:0]   dram_lw_n,
	input  wire [DRAM_DATA_W-1:0]  dram_d,
	output logic [DRAM_DATA_W-1:0] dram_q,
	output logic [DRAM_LANES-1:0]  dram_oe,
	output logic                   ram_rdy,
	// SDRAM channel 1
	input  wire                    ch1_ready,
	input  wire [DRAM_DATA_W-1:0]  ch1_dout,
	output logic [CH1_ADDR_W-1:0]  ch1_addr,
	output logic                   ch1_req,
	output logic                   ch1_rnw,
	output logic [DRAM_BE_W-1:0]   ch1_be,
	output logic [DRAM_DATA_W-1:0] ch1_din
);

	// loader to DDR port
	logic                  loader_active;
	logic                  wr_pending;
	logic                  wr_accept;
	logic [ABUS_W-1:0]     wr_addr;
	logic [DDR_DATA_W-1:0] wr_data;
	logic [DDR_BE_W-1:0]   wr_be;

	cart_loader u_loader (
		.clk_sys, .reset,
		.ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_data,
		.wr_accept,
		.ioctl_wait, .core_run,
		.loader_active, .wr_pending, .wr_addr, .wr_data, .wr_be
	);

	cart_ddr_port u_ddr_port (
		.clk_sys, .reset,
		.loader_active, .wr_pending, .wr_addr, .wr_data, .wr_be,
		.wr_accept,
		.cart_ce_n, .abus, .cart_q, .xwaitl,
		.ddram_busy, .ddram_dout, .ddram_dout_ready,
		.ddram_rd, .ddram_we, .ddram_addr, .ddram_din, .ddram_be
	);

	dram_bridge u_bridge (
		.clk_sys, .reset,
		.abus, .startcas, .dram_cas_n, .dram_oe_n, .dram_uw_n, .dram_lw_n, .dram_d,
		.dram_q, .dram_oe, .ram_rdy,
		.ch1_ready, .ch1_dout,
		.ch1_addr, .ch1_req, .ch1_rnw, .ch1_be, .ch1_din
	);

endmodule

`default_nettype wire

//--- hw/mem_map_pkg.sv
// memory map for the console glue
// bus widths, DDR port widths and where the core's memory lands in DDR
`default_nettype none

package mem_map_pkg;

	// ====================
	// core side
	localparam int ABUS_W       = 24;   // core byte address bus
	localparam int CART_DATA_W  = 32;   // cartridge data toward the core

	// ====================
	// host download side
	localparam int LOAD_WORD_W  = 16;   // one download word
	localparam int IOCTL_IDX_W  = 8;    // download index, 0 is the boot rom

	// ====================
	// DDR side
	localparam int DDR_ADDR_W   = 29;   // 64-bit word address
	localparam int DDR_DATA_W   = 64;
	localparam int DDR_BE_W     = DDR_DATA_W / 8;
	localparam int LOAD_REPEAT  = DDR_DATA_W / LOAD_WORD_W;   // copies of a word per DDR beat

	// upper DDR address bits, rest comes from the byte address bits 23..3
	localparam logic [7:0] DDR_REGION = 8'h30;

	// cart image lives at 0x800000 inside the region
	localparam logic [ABUS_W-1:0] CART_LOAD_BASE = 24'h80_0000;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the memory glue testbench with Verilator, runs it and checks the log

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_jag_mem_glue -o tb_sim > "$LOG" 2>&1 \
	&& ./obj_dir/tb_sim >> "$LOG" 2>&1 \
	|| { echo "build or run failed, see $LOG"; exit 1; }

grep -q '^\*\*\* PASSED \*\*\*$' "$LOG" && echo "simulation passed" \
	|| { echo "simulation failed, see $LOG"; exit 1; }

//--- sim/tb_jag_mem_glue.sv
// testbench for the memory glue
// drives load, cart reads and DRAM accesses, concurrent assertions check them
`timescale 1ns/1ps
`default_nettype none

module tb_jag_mem_glue import mem_map_pkg::*; import dram_bus_pkg::*; ;

	localparam int LIMIT = 200;   // cycles per wait

	logic clk_sys, reset;
	logic ioctl_download, ioctl_wr, ioctl_wait, core_run;
	logic [IOCTL_IDX_W-1:0] ioctl_index;
	logic [LOAD_WORD_W-1:0] ioctl_data;
	logic cart_ce_n, xwaitl;
	logic [ABUS_W-1:0] abus;
	logic [CART_DATA_W-1:0] cart_q;
	logic ddram_busy, ddram_dout_ready, ddram_rd, ddram_we;
	logic [DDR_DATA_W-1:0] ddram_dout, ddram_din;
	logic [DDR_ADDR_W-1:0] ddram_addr;
	logic [DDR_BE_W-1:0] ddram_be;
	logic startcas, dram_cas_n, ram_rdy, ch1_ready, ch1_req, ch1_rnw;
	logic [DRAM_LANES-1:0] dram_oe_n, dram_uw_n, dram_lw_n, dram_oe;
	logic [DRAM_DATA_W-1:0] dram_d, dram_q, ch1_dout, ch1_din;
	logic [CH1_ADDR_W-1:0] ch1_addr;
	logic [DRAM_BE_W-1:0] ch1_be;

	// scoreboard state
	int err_count, acc_count, rd_count, req_count, tests_run, tests_failed;
	logic [LOAD_WORD_W-1:0] words [16];
	logic rd_phase, dram_reading;
	logic [DRAM_BE_W-1:0] exp_be;
	logic [DRAM_DATA_W-1:0] exp_din, exp_q;

	jag_mem_glue DUT (.*);

	ddram_model u_ddr (.clk_sys, .reset, .rd(ddram_rd), .addr(ddram_addr),
		.busy(ddram_busy), .dout(ddram_dout), .dout_ready(ddram_dout_ready));

	sdram_ch_model u_sdram (.clk_sys, .reset, .addr(ch1_addr), .req(ch1_req),
		.rnw(ch1_rnw), .be(ch1_be), .din(ch1_din), .ready(ch1_ready), .dout(ch1_dout));

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic note_error(input string msg);
		err_count++;
		$display("error %0t ns: %s", $time, msg);
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("*** FAILED ***");
		$finish;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (err_count != err_before)
			tests_failed++;
		$display("test %s done, %0d new errors", name, err_count - err_before);
	endtask

	// top pair for addr[2:1] == 0, bottom pair for 3
	function automatic logic [7:0] pair_be(input logic [ABUS_W-1:0] a);
		return 8'b11 << (2 * (3 - a[2:1]));
	endfunction

	// byte address of the k-th download word
	function automatic logic [ABUS_W-1:0] load_byte_addr(input int k);
		return CART_LOAD_BASE + ABUS_W'(2 * k);
	endfunction

	// region bits on top of byte address bits 23..3
	function automatic logic [DDR_ADDR_W-1:0] ddr_word_addr(input logic [ABUS_W-1:0] a);
		return {DDR_REGION, a[ABUS_W-1:3]};
	endfunction

	// channel word address, 64-bit aligned
	function automatic logic [CH1_ADDR_W-1:0] sdram_word_addr(input logic [ABUS_W-1:0] a);
		return {4'b0, a[22:3], 2'b00};
	endfunction

	function automatic logic [DRAM_DATA_W-1:0] be_mask(input logic [DRAM_BE_W-1:0] be);
		logic [DRAM_DATA_W-1:0] m;
		for (int j = 0; j < DRAM_BE_W; j++)
			m[8*j +: 8] = {8{be[j]}};
		return m;
	endfunction

	// counters of accepted transfers
	always @(posedge clk_sys) begin
		if (ddram_we && !ddram_busy)
			acc_count <= acc_count + 1;
		if (ddram_rd && !ddram_busy)
			rd_count <= rd_count + 1;
		if (ch1_req)
			req_count <= req_count + 1;
	end

	// ====================
	// load checks
	a_load_write: assert property (@(posedge clk_sys) disable iff (reset)
		ddram_we && !ddram_busy |->
			ddram_addr == ddr_word_addr(load_byte_addr(acc_count))
			&& ddram_din == {4{words[acc_count % 16][7:0], words[acc_count % 16][15:8]}}
			&& ddram_be == pair_be(load_byte_addr(acc_count)))
		else note_error("load write address, data or byte enables wrong");
	a_wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr && ioctl_download |=> ioctl_wait)
		else note_error("ioctl_wait not raised after strobe");
	a_wait_hold: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait && !(ddram_we && !ddram_busy) |=> ioctl_wait)
		else note_error("ioctl_wait dropped before acceptance");
	a_core_held: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_download |-> !core_run) else note_error("core_run high in download");
	a_no_rd_load: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_download |-> !ddram_rd) else note_error("read raised during load");
	a_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ddram_rd && ddram_we)) else note_error("ddram_rd and ddram_we together");

	// ====================
	// cart read checks
	a_rd_addr: assert property (@(posedge clk_sys) disable iff (reset)
		ddram_rd && !ddram_busy |-> ddram_addr == {DDR_REGION, abus[23:3]})
		else note_error("read address wrong");
	a_wait_low: assert property (@(posedge clk_sys) disable iff (reset)
		rd_phase && $changed(abus) |=> !xwaitl) else note_error("xwaitl not low");
	a_wait_keep: assert property (@(posedge clk_sys) disable iff (reset)
		rd_phase && !xwaitl && !ddram_dout_ready |=> !xwaitl)
		else note_error("xwaitl high before data");
	a_wait_end: assert property (@(posedge clk_sys) disable iff (reset)
		rd_phase && ddram_dout_ready |=> xwaitl) else note_error("xwaitl stuck low");
	a_cart_q: assert property (@(posedge clk_sys) disable iff (reset)
		ddram_dout_ready |-> cart_q == (abus[2] ? ddram_dout[31:0] : ddram_dout[63:32]))
		else note_error("cart_q half wrong");

	// ====================
	// DRAM bridge checks
	a_req: assert property (@(posedge clk_sys) disable iff (reset)
		ch1_req |-> ch1_addr == sdram_word_addr(abus) && ch1_rnw == dram_reading
			&& (dram_reading || (ch1_be == exp_be && ch1_din == exp_din)))
		else note_error("channel request fields wrong");
	a_rd_data: assert property (@(posedge clk_sys) disable iff (reset)
		ram_rdy && dram_reading |-> dram_q == exp_q) else note_error("dram_q wrong");
	a_oe: assert property (@(posedge clk_sys) disable iff (reset)
		!dram_cas_n |-> dram_oe == ~dram_oe_n) else note_error("dram_oe wrong");
	a_oe_off: assert property (@(posedge clk_sys) disable iff (reset)
		dram_cas_n |-> dram_oe == 4'b0) else note_error("dram_oe high without cas");

	initial begin
		int n, e0;
		logic [CH1_ADDR_W-1:0] exp_addr;
		void'($urandom(42));
		{err_count, acc_count, rd_count, req_count, tests_run, tests_failed} = '0;
		{ioctl_download, ioctl_wr, ioctl_index, ioctl_data} = '0;
		{cart_ce_n, abus, rd_phase, dram_reading} = {1'b1, 24'h0, 2'b0};
		{startcas, dram_cas_n, dram_oe_n, dram_uw_n, dram_lw_n, dram_d} = {2'b01, 12'hfff, 64'h0};
		{exp_be, exp_din, exp_q} = '0;
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;

		e0 = err_count;   // after reset
		@(negedge clk_sys);
		assert (!ioctl_wait && !ddram_rd && !ddram_we && !ch1_req && xwaitl)
			else note_error("outputs not idle after reset");
		end_test("reset", e0);

		e0 = err_count;   // cartridge load with abus moving
		ioctl_index = 8'd1;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		cart_ce_n = 1'b0;   // loader owns the port by now
		for (int k = 0; k < 16; k++) begin
			words[k] = LOAD_WORD_W'($urandom);
			ioctl_data = words[k];
			ioctl_wr = 1'b1;
			abus = ABUS_W'($urandom);
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			n = 0;
			while (ioctl_wait && n < LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			if (n >= LIMIT)
				timeout_fail("load write acceptance");
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		assert (acc_count == 16) else note_error("load write count wrong");
		end_test("cart load", e0);

		e0 = err_count;   // cartridge reads
		rd_count = 0;
		rd_phase = 1'b1;
		for (int i = 0; i < 12; i++) begin
			abus = ABUS_W'($urandom);
			@(negedge clk_sys);
			n = 0;
			while (!xwaitl && n < LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			if (n >= LIMIT)
				timeout_fail("cart read data");
			assert (rd_count == i + 1) else note_error("read count wrong");
		end
		rd_phase = 1'b0;
		cart_ce_n = 1'b1;
		end_test("cart read", e0);

		e0 = err_count;   // DRAM write, random lane masks
		req_count = 0;
		abus = ABUS_W'($urandom);
		{dram_uw_n, dram_lw_n} = 8'($urandom) & 8'hfe;   // at least one byte
		// lane 3 down to lane 0, upper byte before lower
		exp_be = {~dram_uw_n[3], ~dram_lw_n[3], ~dram_uw_n[2], ~dram_lw_n[2],
			~dram_uw_n[1], ~dram_lw_n[1], ~dram_uw_n[0], ~dram_lw_n[0]};
		dram_d = {$urandom, $urandom};
		exp_din = dram_d;
		dram_cas_n = 1'b0;
		n = 0;
		while (!ram_rdy && n < LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (n >= LIMIT)
			timeout_fail("DRAM write ready");
		{dram_cas_n, dram_uw_n, dram_lw_n} = 9'h1ff;
		repeat (2) @(negedge clk_sys);
		exp_addr = sdram_word_addr(abus);
		// model fill pattern under the bytes not written
		exp_q = ({6'h2b, exp_addr, 6'h15, ~exp_addr} & ~be_mask(exp_be))
			| (exp_din & be_mask(exp_be));
		assert (req_count == 1) else note_error("write request count wrong");
		end_test("dram write", e0);

		e0 = err_count;   // DRAM read back, same abus
		req_count = 0;
		dram_reading = 1'b1;
		{startcas, dram_cas_n, dram_oe_n} = 6'b100000;
		@(negedge clk_sys);
		startcas = 1'b0;
		n = 0;
		while (!ram_rdy && n < LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (n >= LIMIT)
			timeout_fail("DRAM read ready");
		{dram_cas_n, dram_oe_n} = 5'h1f;
		repeat (2) @(negedge clk_sys);
		dram_reading = 1'b0;
		assert (req_count == 1) else note_error("read request count wrong");
		end_test("dram read", e0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_mem_models.sv
// memory models for the glue testbench
// DDR with random busy and read latency, SDRAM channel with real storage
`timescale 1ns/1ps
`default_nettype none

module ddram_model import mem_map_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   rd,
	input  wire [DDR_ADDR_W-1:0]  addr,
	output logic                  busy,
	output logic [DDR_DATA_W-1:0] dout,
	output logic                  dout_ready
);

	int                  lat;       // cycles left on the open read
	logic [DDR_ADDR_W-1:0] rd_addr;

	// data is a pure function of the word address
	function automatic logic [DDR_DATA_W-1:0] read_data(input logic [DDR_ADDR_W-1:0] a);
		return {a ^ 29'h0A5A_5A5, 3'b101, ~a, 3'b010};
	endfunction

	initial busy = 1'b0;
	always @(negedge clk_sys)
		busy <= ($urandom % 4) == 0;   // about one cycle in four

	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			lat        <= 0;
			dout_ready <= 1'b0;
			dout       <= '0;
		end else begin
			dout_ready <= 1'b0;
			if (rd && !busy) begin
				lat     <= 1 + int'($urandom % 6);
				rd_addr <= addr;
			end else if (lat == 1) begin
				dout       <= read_data(rd_addr);
				dout_ready <= 1'b1;
				lat        <= 0;
			end else if (lat > 1)
				lat <= lat - 1;
		end
	end

endmodule

module sdram_ch_model import dram_bus_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire [CH1_ADDR_W-1:0]   addr,
	input  wire                    req,
	input  wire                    rnw,
	input  wire [DRAM_BE_W-1:0]    be,
	input  wire [DRAM_DATA_W-1:0]  din,
	output logic                   ready,
	output logic [DRAM_DATA_W-1:0] dout
);

	logic [DRAM_DATA_W-1:0] mem [logic [CH1_ADDR_W-1:0]];
	int                     lat;
	logic [CH1_ADDR_W-1:0]  a_q;
	logic                   rnw_q;
	logic [DRAM_BE_W-1:0]   be_q;
	logic [DRAM_DATA_W-1:0] din_q;

	// unwritten words read back a pattern of their address
	function automatic logic [DRAM_DATA_W-1:0] word_at(input logic [CH1_ADDR_W-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return {6'h2b, a, 6'h15, ~a};
	endfunction

	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			lat   <= 0;
			ready <= 1'b0;
			dout  <= '0;
		end else begin
			ready <= 1'b0;
			if (req) begin
				lat   <= 1 + int'($urandom % 5);
				a_q   <= addr;
				rnw_q <= rnw;
				be_q  <= be;
				din_q <= din;
			end else if (lat == 1) begin
				if (rnw_q)
					dout <= word_at(a_q);
				else
					for (int j = 0; j < DRAM_BE_W; j++)
						if (be_q[j])
							mem[a_q] = {word_at(a_q)} & ~(64'hff << (8*j))
								| (din_q & (64'hff << (8*j)));
				ready <= 1'b1;
				lat   <= 0;
			end else if (lat > 1)
				lat <= lat - 1;
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/mem_map_pkg.sv
hw/dram_bus_pkg.sv
hw/cart_loader.sv
hw/cart_ddr_port.sv
hw/dram_bridge.sv
hw/jag_mem_glue.sv
sim/tb_mem_models.sv
sim/tb_jag_mem_glue.sv
